//--- design/hyper_stream_pkg.sv
// Payload types of the HyperBus transaction, write, read and response streams; import where used
package hyper_stream_pkg;

    // PHY word width
    localparam int unsigned DataWidth = 16;
    localparam int unsigned StrbWidth = DataWidth / 8;

    // One HyperBus transaction as handed to the PHY
    typedef struct packed {
        logic        write;
        logic [31:0] address;
        // Number of beats
        logic [15:0] burst;
        // 1 = linear, 0 = wrapped
        logic        burst_type;
        // 1 = register space, 0 = memory
        logic        address_space;
    } hyper_tf_t;

    // Write beat towards the PHY
    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic [StrbWidth-1:0] strb;
        logic                 last;
    } hyper_tx_t;

    // Read beat from the PHY
    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic                 last;
        logic                 error;
    } hyper_rx_t;

endpackage

//--- design/hyper_arb_pkg.sv
// Initiator identity shared by the PHY arbiter, the path switch and the testbench
package hyper_arb_pkg;

    // Owner of the PHY
    typedef enum logic {
        INIT_AXI  = 1'b0,
        INIT_UDMA = 1'b1
    } hyper_init_e;

endpackage

//--- design/hyper_arbiter.sv
// Round-robin arbiter that grants the shared PHY and holds it for one whole transaction
`timescale 1ns/100ps

module hyper_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Requests seen at the initiators
    input  logic                        axi_trans_valid_i,
    input  logic                        udma_trans_valid_i,
    // PHY side handshakes
    input  logic                        phy_trans_valid_i,
    input  logic                        phy_trans_ready_i,
    input  logic                        phy_trans_write_i,
    input  logic                        phy_rx_valid_i,
    input  logic                        phy_rx_ready_i,
    input  logic                        phy_rx_last_i,
    input  logic                        phy_b_valid_i,
    input  logic                        phy_b_ready_i,
    output hyper_arb_pkg::hyper_init_e  sel_o,
    output logic                        grant_open_o
);
    import hyper_arb_pkg::*;

    typedef enum logic {
        LOCK_IDLE,
        LOCK_HELD
    } lock_e;

    lock_e       lock_q;
    // Owner while locked, last winner while idle
    hyper_init_e owner_q;
    logic        write_q;

    hyper_init_e pick;
    logic        trans_hs;
    logic        rx_done;
    logic        b_done;

    // Tie goes to the initiator that lost last time
    always_comb begin
        if (axi_trans_valid_i && udma_trans_valid_i) begin
            pick = (owner_q == INIT_AXI) ? INIT_UDMA : INIT_AXI;
        end else if (udma_trans_valid_i) begin
            pick = INIT_UDMA;
        end else begin
            pick = INIT_AXI;
        end
    end

    assign grant_open_o = (lock_q == LOCK_IDLE);
    assign sel_o        = grant_open_o ? pick : owner_q;

    assign trans_hs = phy_trans_valid_i && phy_trans_ready_i;
    assign rx_done  = phy_rx_valid_i && phy_rx_ready_i && phy_rx_last_i;
    assign b_done   = phy_b_valid_i && phy_b_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lock_q  <= LOCK_IDLE;
            owner_q <= INIT_UDMA;
            write_q <= 1'b0;
        end else begin
            case (lock_q)
                LOCK_IDLE: begin
                    if (trans_hs) begin
                        lock_q  <= LOCK_HELD;
                        owner_q <= pick;
                        write_q <= phy_trans_write_i;
                    end
                end
                default: begin
                    // Writes release on the response, reads on the last beat
                    if (write_q) begin
                        if (b_done) begin
                            lock_q <= LOCK_IDLE;
                        end
                    end else if (rx_done) begin
                        lock_q <= LOCK_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/hyper_path_switch.sv
// Combinational switch steering initiator streams to the PHY and PHY streams back to the owner
`timescale 1ns/100ps

module hyper_path_switch #(
    parameter int unsigned NumChips = 2
) (
    // AXI initiator
    input  hyper_stream_pkg::hyper_tf_t  axi_trans_i,
    input  logic [NumChips-1:0]          axi_trans_cs_i,
    input  logic                         axi_trans_valid_i,
    output logic                         axi_trans_ready_o,
    input  hyper_stream_pkg::hyper_tx_t  axi_tx_i,
    input  logic                         axi_tx_valid_i,
    output logic                         axi_tx_ready_o,
    output hyper_stream_pkg::hyper_rx_t  axi_rx_o,
    output logic                         axi_rx_valid_o,
    input  logic                         axi_rx_ready_i,
    output logic                         axi_b_error_o,
    output logic                         axi_b_valid_o,
    input  logic                         axi_b_ready_i,
    // uDMA initiator
    input  hyper_stream_pkg::hyper_tf_t  udma_trans_i,
    input  logic [NumChips-1:0]          udma_trans_cs_i,
    input  logic                         udma_trans_valid_i,
    output logic                         udma_trans_ready_o,
    input  hyper_stream_pkg::hyper_tx_t  udma_tx_i,
    input  logic                         udma_tx_valid_i,
    output logic                         udma_tx_ready_o,
    output hyper_stream_pkg::hyper_rx_t  udma_rx_o,
    output logic                         udma_rx_valid_o,
    input  logic                         udma_rx_ready_i,
    // PHY
    output hyper_stream_pkg::hyper_tf_t  phy_trans_o,
    output logic [NumChips-1:0]          phy_trans_cs_o,
    output logic                         phy_trans_valid_o,
    input  logic                         phy_trans_ready_i,
    output hyper_stream_pkg::hyper_tx_t  phy_tx_o,
    output logic                         phy_tx_valid_o,
    input  logic                         phy_tx_ready_i,
    input  hyper_stream_pkg::hyper_rx_t  phy_rx_i,
    input  logic                         phy_rx_valid_i,
    output logic                         phy_rx_ready_o,
    input  logic                         phy_b_error_i,
    input  logic                         phy_b_valid_i,
    output logic                         phy_b_ready_o,
    // Arbiter
    input  hyper_arb_pkg::hyper_init_e   sel_i,
    input  logic                         grant_open_i
);
    import hyper_arb_pkg::*;

    logic to_axi;
    logic to_udma;

    assign to_axi  = (sel_i == INIT_AXI);
    assign to_udma = (sel_i == INIT_UDMA);

    // New transactions only pass while the arbiter is not locked
    assign phy_trans_o        = to_axi ? axi_trans_i : udma_trans_i;
    assign phy_trans_cs_o     = to_axi ? axi_trans_cs_i : udma_trans_cs_i;
    assign phy_trans_valid_o  = grant_open_i
                                && (to_axi ? axi_trans_valid_i : udma_trans_valid_i);
    assign axi_trans_ready_o  = grant_open_i && to_axi && phy_trans_ready_i;
    assign udma_trans_ready_o = grant_open_i && to_udma && phy_trans_ready_i;

    // Write data
    assign phy_tx_o        = to_axi ? axi_tx_i : udma_tx_i;
    assign phy_tx_valid_o  = to_axi ? axi_tx_valid_i : udma_tx_valid_i;
    assign axi_tx_ready_o  = to_axi && phy_tx_ready_i;
    assign udma_tx_ready_o = to_udma && phy_tx_ready_i;

    // Read payload goes to both, valid only to the owner
    assign axi_rx_o        = phy_rx_i;
    assign udma_rx_o       = phy_rx_i;
    assign axi_rx_valid_o  = to_axi && phy_rx_valid_i;
    assign udma_rx_valid_o = to_udma && phy_rx_valid_i;
    assign phy_rx_ready_o  = to_axi ? axi_rx_ready_i : udma_rx_ready_i;

    // uDMA has no response port, its responses are dropped here
    assign axi_b_error_o = to_axi && phy_b_error_i;
    assign axi_b_valid_o = to_axi && phy_b_valid_i;
    assign phy_b_ready_o = to_udma || axi_b_ready_i;

endmodule

//--- design/hyperbus_mux_top.sv
// Top level sharing one HyperBus PHY between the AXI and uDMA front ends
`timescale 1ns/100ps

module hyperbus_mux_top #(
    parameter int unsigned NumChips = 2
) (
    input  logic                         clk_phy_i,
    input  logic                         rst_i,
    // AXI initiator
    input  hyper_stream_pkg::hyper_tf_t  axi_trans_i,
    input  logic [NumChips-1:0]          axi_trans_cs_i,
    input  logic                         axi_trans_valid_i,
    output logic                         axi_trans_ready_o,
    input  hyper_stream_pkg::hyper_tx_t  axi_tx_i,
    input  logic                         axi_tx_valid_i,
    output logic                         axi_tx_ready_o,
    output hyper_stream_pkg::hyper_rx_t  axi_rx_o,
    output logic                         axi_rx_valid_o,
    input  logic                         axi_rx_ready_i,
    output logic                         axi_b_error_o,
    output logic                         axi_b_valid_o,
    input  logic                         axi_b_ready_i,
    // uDMA initiator
    input  hyper_stream_pkg::hyper_tf_t  udma_trans_i,
    input  logic [NumChips-1:0]          udma_trans_cs_i,
    input  logic                         udma_trans_valid_i,
    output logic                         udma_trans_ready_o,
    input  hyper_stream_pkg::hyper_tx_t  udma_tx_i,
    input  logic                         udma_tx_valid_i,
    output logic                         udma_tx_ready_o,
    output hyper_stream_pkg::hyper_rx_t  udma_rx_o,
    output logic                         udma_rx_valid_o,
    input  logic                         udma_rx_ready_i,
    // PHY
    output hyper_stream_pkg::hyper_tf_t  phy_trans_o,
    output logic [NumChips-1:0]          phy_trans_cs_o,
    output logic                         phy_trans_valid_o,
    input  logic                         phy_trans_ready_i,
    output hyper_stream_pkg::hyper_tx_t  phy_tx_o,
    output logic                         phy_tx_valid_o,
    input  logic                         phy_tx_ready_i,
    input  hyper_stream_pkg::hyper_rx_t  phy_rx_i,
    input  logic                         phy_rx_valid_i,
    output logic                         phy_rx_ready_o,
    input  logic                         phy_b_error_i,
    input  logic                         phy_b_valid_i,
    output logic                         phy_b_ready_o
);
    import hyper_arb_pkg::*;

    hyper_init_e sel;
    logic        grant_open;

    // Arbiter watches the PHY side of the switch
    hyper_arbiter i_arbiter (
        .clk_i              ( clk_phy_i          ),
        .rst_i              ( rst_i              ),
        .axi_trans_valid_i  ( axi_trans_valid_i  ),
        .udma_trans_valid_i ( udma_trans_valid_i ),
        .phy_trans_valid_i  ( phy_trans_valid_o  ),
        .phy_trans_ready_i  ( phy_trans_ready_i  ),
        .phy_trans_write_i  ( phy_trans_o.write  ),
        .phy_rx_valid_i     ( phy_rx_valid_i     ),
        .phy_rx_ready_i     ( phy_rx_ready_o     ),
        .phy_rx_last_i      ( phy_rx_i.last      ),
        .phy_b_valid_i      ( phy_b_valid_i      ),
        .phy_b_ready_i      ( phy_b_ready_o      ),
        .sel_o              ( sel                ),
        .grant_open_o       ( grant_open         )
    );

    hyper_path_switch #(
        .NumChips ( NumChips )
    ) i_switch (
        .axi_trans_i,
        .axi_trans_cs_i,
        .axi_trans_valid_i,
        .axi_trans_ready_o,
        .axi_tx_i,
        .axi_tx_valid_i,
        .axi_tx_ready_o,
        .axi_rx_o,
        .axi_rx_valid_o,
        .axi_rx_ready_i,
        .axi_b_error_o,
        .axi_b_valid_o,
        .axi_b_ready_i,
        .udma_trans_i,
        .udma_trans_cs_i,
        .udma_trans_valid_i,
        .udma_trans_ready_o,
        .udma_tx_i,
        .udma_tx_valid_i,
        .udma_tx_ready_o,
        .udma_rx_o,
        .udma_rx_valid_o,
        .udma_rx_ready_i,
        .phy_trans_o,
        .phy_trans_cs_o,
        .phy_trans_valid_o,
        .phy_trans_ready_i,
        .phy_tx_o,
        .phy_tx_valid_o,
        .phy_tx_ready_i,
        .phy_rx_i,
        .phy_rx_valid_i,
        .phy_rx_ready_o,
        .phy_b_error_i,
        .phy_b_valid_i,
        .phy_b_ready_o,
        .sel_i        ( sel        ),
        .grant_open_i ( grant_open )
    );

endmodule

//--- testbench/tb_hyperbus_mux.sv
// Self-checking testbench that runs a table of AXI and uDMA transactions through the mux top
`timescale 1ns/100ps

module tb_hyperbus_mux;
    import hyper_stream_pkg::*;
    import hyper_arb_pkg::*;

    localparam int unsigned NumChips = 2;
    localparam int          NumRows  = 8;
    localparam int          Limit    = 64;

    // Requesters in req are AXI in bit 0 and uDMA in bit 1
    typedef struct packed {
        logic [1:0]          req;
        // Expected winner of the first grant
        hyper_init_e         first;
        logic                write;
        logic [31:0]         address;
        logic [15:0]         burst;
        logic [NumChips-1:0] cs;
        logic                err;
        logic                stall;
    } row_t;

    logic                clk_phy_i;
    logic                rst_i;
    hyper_tf_t           axi_trans_i, udma_trans_i, phy_trans_o;
    logic [NumChips-1:0] axi_trans_cs_i, udma_trans_cs_i, phy_trans_cs_o;
    hyper_tx_t           axi_tx_i, udma_tx_i, phy_tx_o;
    hyper_rx_t           axi_rx_o, udma_rx_o, phy_rx_i;
    logic axi_trans_valid_i, axi_trans_ready_o, axi_tx_valid_i, axi_tx_ready_o;
    logic axi_rx_valid_o, axi_rx_ready_i, axi_b_error_o, axi_b_valid_o, axi_b_ready_i;
    logic udma_trans_valid_i, udma_trans_ready_o, udma_tx_valid_i, udma_tx_ready_o;
    logic udma_rx_valid_o, udma_rx_ready_i;
    logic phy_trans_valid_o, phy_trans_ready_i, phy_tx_valid_o, phy_tx_ready_i;
    logic phy_rx_valid_i, phy_rx_ready_o, phy_b_error_i, phy_b_valid_i, phy_b_ready_o;

    row_t   rows [NumRows];
    integer seed;
    int     value_errors;
    int     timeouts;

    hyperbus_mux_top #(.NumChips(NumChips)) i_dut (.*);

    initial begin
        clk_phy_i = 1'b0;
        forever #2 clk_phy_i = ~clk_phy_i;
    end

    task automatic mismatch(input string msg);
        value_errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic timed_out(input string msg);
        timeouts++;
        $display("Timeout at %0t ns: %s", $time, msg);
    endtask

    task automatic check_trans(input hyper_tf_t got, input hyper_tf_t exp,
                               input logic [NumChips-1:0] got_cs,
                               input logic [NumChips-1:0] exp_cs);
        if (got !== exp || got_cs !== exp_cs) begin
            mismatch($sformatf("PHY transaction %h cs %b, expected %h cs %b",
                               got, got_cs, exp, exp_cs));
        end
    endtask

    task automatic check_tx(input hyper_tx_t got, input hyper_tx_t exp);
        if (got !== exp) mismatch($sformatf("PHY write beat %h, expected %h", got, exp));
    endtask

    task automatic check_rx(input hyper_rx_t got, input hyper_rx_t exp);
        if (got !== exp) mismatch($sformatf("read beat %h, expected %h", got, exp));
    endtask

    task automatic check_b(input logic got, input logic exp);
        if (got !== exp) mismatch($sformatf("AXI response error %b, expected %b", got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // Inputs change 1 ns after the edge and outputs are sampled 1 ns later
    task automatic drive_point;
        @(posedge clk_phy_i);
        #1;
    endtask

    function automatic hyper_tf_t make_trans(input row_t row, input hyper_init_e who);
        hyper_tf_t tf;
        tf.write         = row.write;
        tf.address       = (who == INIT_AXI) ? row.address : row.address + 32'h0001_0000;
        tf.burst         = row.burst;
        tf.burst_type    = (who == INIT_AXI);
        tf.address_space = (who == INIT_UDMA);
        return tf;
    endfunction

    function automatic logic [NumChips-1:0] make_cs(input row_t row, input hyper_init_e who);
        return (who == INIT_AXI) ? row.cs : ~row.cs;
    endfunction

    // Grant is closed and the other initiator sees nothing
    task automatic check_locked(input hyper_init_e owner);
        check_bit(phy_trans_valid_o, 1'b0, "PHY transaction valid while locked");
        check_bit(axi_trans_ready_o | udma_trans_ready_o, 1'b0, "transaction ready while locked");
        check_bit((owner == INIT_AXI) ? udma_rx_valid_o : axi_rx_valid_o, 1'b0,
                  "read valid at the other initiator");
        check_bit((owner == INIT_AXI) ? udma_tx_ready_o : axi_tx_ready_o, 1'b0,
                  "write ready at the other initiator");
    endtask

    task automatic read_phase(input row_t row, input hyper_init_e owner);
        hyper_rx_t   beat;
        logic [31:0] r;
        logic        ready;
        int          n;
        int          burst;
        burst = int'(row.burst);
        for (int i = 0; i < burst; i++) begin
            r          = $random(seed);
            beat.data  = r[15:0];
            beat.last  = (i == burst - 1);
            beat.error = r[16];
            ready      = 1'b0;
            n          = 0;
            while (!ready && n < Limit) begin
                r               = $random(seed);
                ready           = !row.stall || r[0];
                phy_rx_i        = beat;
                phy_rx_valid_i  = 1'b1;
                axi_rx_ready_i  = (owner == INIT_AXI) ? ready : !ready;
                udma_rx_ready_i = (owner == INIT_UDMA) ? ready : !ready;
                #1;
                check_bit((owner == INIT_AXI) ? axi_rx_valid_o : udma_rx_valid_o, 1'b1,
                          "read valid at the owner");
                check_rx((owner == INIT_AXI) ? axi_rx_o : udma_rx_o, beat);
                check_bit(phy_rx_ready_o, ready, "PHY read ready");
                check_locked(owner);
                n++;
                drive_point();
            end
            if (!ready) timed_out("read beat was never accepted");
        end
        phy_rx_valid_i = 1'b0;
    endtask

    task automatic write_phase(input row_t row, input hyper_init_e owner);
        hyper_tx_t   beat;
        logic [31:0] r;
        logic        ready;
        int          n;
        int          burst;
        burst = int'(row.burst);
        for (int i = 0; i < burst; i++) begin
            r         = $random(seed);
            beat.data = r[15:0];
            beat.strb = r[17:16];
            beat.last = (i == burst - 1);
            ready     = 1'b0;
            n         = 0;
            while (!ready && n < Limit) begin
                r              = $random(seed);
                ready          = !row.stall || r[0];
                phy_tx_ready_i = ready;
                if (owner == INIT_AXI) begin
                    axi_tx_i       = beat;
                    axi_tx_valid_i = 1'b1;
                end else begin
                    udma_tx_i       = beat;
                    udma_tx_valid_i = 1'b1;
                end
                #1;
                check_bit(phy_tx_valid_o, 1'b1, "PHY write valid");
                check_tx(phy_tx_o, beat);
                check_bit((owner == INIT_AXI) ? axi_tx_ready_o : udma_tx_ready_o, ready,
                          "write ready at the owner");
                check_locked(owner);
                n++;
                drive_point();
            end
            if (!ready) timed_out("write beat was never accepted");
        end
        axi_tx_valid_i  = 1'b0;
        udma_tx_valid_i = 1'b0;
        // One response from the PHY, dropped inside the DUT for uDMA
        phy_b_valid_i = 1'b1;
        phy_b_error_i = row.err;
        ready         = 1'b0;
        n             = 0;
        while (!ready && n < Limit) begin
            r             = $random(seed);
            axi_b_ready_i = !row.stall || r[0];
            #1;
            if (owner == INIT_AXI) begin
                check_bit(axi_b_valid_o, 1'b1, "AXI response valid");
                check_b(axi_b_error_o, row.err);
                ready = axi_b_ready_i;
            end else begin
                check_bit(axi_b_valid_o, 1'b0, "AXI response valid during a uDMA write");
                ready = 1'b1;
            end
            check_bit(phy_b_ready_o, ready, "PHY response ready");
            check_locked(owner);
            n++;
            drive_point();
        end
        phy_b_valid_i = 1'b0;
        if (!ready) timed_out("write response was never accepted");
    endtask

    task automatic serve(input row_t row, input hyper_init_e owner, input logic queued);
        hyper_tf_t   exp_tf;
        logic [31:0] r;
        logic        taken;
        int          n;
        exp_tf = make_trans(row, owner);
        taken  = 1'b0;
        n      = 0;
        // The PHY may hold off the transaction on stalled rows
        while (!taken && n < Limit) begin
            r                 = $random(seed);
            phy_trans_ready_i = !row.stall || r[0];
            #1;
            // A waiting request is presented in the first idle cycle
            if (queued && n == 0) begin
                check_bit(phy_trans_valid_o, 1'b1, "PHY transaction valid after release");
            end
            if (phy_trans_valid_o) begin
                check_trans(phy_trans_o, exp_tf, phy_trans_cs_o, make_cs(row, owner));
                check_bit((owner == INIT_AXI) ? axi_trans_ready_o : udma_trans_ready_o,
                          phy_trans_ready_i, "transaction ready at the winner");
                check_bit((owner == INIT_AXI) ? udma_trans_ready_o : axi_trans_ready_o, 1'b0,
                          "transaction ready at the loser");
                taken = phy_trans_ready_i;
            end
            n++;
            drive_point();
        end
        if (!taken) begin
            timed_out("no transaction reached the PHY in time");
            return;
        end
        if (owner == INIT_AXI) axi_trans_valid_i = 1'b0;
        else udma_trans_valid_i = 1'b0;
        if (row.write) write_phase(row, owner);
        else read_phase(row, owner);
    endtask

    task automatic run_row(input row_t row);
        drive_point();
        axi_trans_i        = make_trans(row, INIT_AXI);
        axi_trans_cs_i     = make_cs(row, INIT_AXI);
        axi_trans_valid_i  = row.req[0];
        udma_trans_i       = make_trans(row, INIT_UDMA);
        udma_trans_cs_i    = make_cs(row, INIT_UDMA);
        udma_trans_valid_i = row.req[1];
        serve(row, row.first, 1'b0);
        if (row.req == 2'b11) begin
            serve(row, (row.first == INIT_AXI) ? INIT_UDMA : INIT_AXI, 1'b1);
        end
        #1;
        check_bit(axi_b_valid_o, 1'b0, "AXI response valid after the response");
        check_bit(axi_rx_valid_o | udma_rx_valid_o, 1'b0, "read valid after the last beat");
    endtask

    initial begin
        seed = 11;
        value_errors = 0;
        timeouts = 0;
        rst_i = 1'b1;
        axi_trans_i = '0;
        axi_trans_cs_i = '0;
        axi_trans_valid_i = 1'b0;
        axi_tx_i = '0;
        axi_tx_valid_i = 1'b0;
        axi_rx_ready_i = 1'b1;
        axi_b_ready_i = 1'b1;
        udma_trans_i = '0;
        udma_trans_cs_i = '0;
        udma_trans_valid_i = 1'b0;
        udma_tx_i = '0;
        udma_tx_valid_i = 1'b0;
        udma_rx_ready_i = 1'b1;
        phy_trans_ready_i = 1'b1;
        phy_tx_ready_i = 1'b1;
        phy_rx_i = '0;
        phy_rx_valid_i = 1'b0;
        phy_b_error_i = 1'b0;
        phy_b_valid_i = 1'b0;
        // Ties go AXI, uDMA, AXI since the single requests in between move the last winner
        rows[0] = '{2'b11, INIT_AXI,  1'b0, 32'h0000_1000, 16'd4, 2'b01, 1'b0, 1'b0};
        rows[1] = '{2'b10, INIT_UDMA, 1'b1, 32'h0000_2000, 16'd3, 2'b10, 1'b1, 1'b1};
        rows[2] = '{2'b01, INIT_AXI,  1'b1, 32'h0000_3000, 16'd2, 2'b10, 1'b1, 1'b0};
        rows[3] = '{2'b11, INIT_UDMA, 1'b1, 32'h0000_4000, 16'd3, 2'b01, 1'b0, 1'b1};
        rows[4] = '{2'b10, INIT_UDMA, 1'b0, 32'h0000_5000, 16'd5, 2'b11, 1'b0, 1'b1};
        rows[5] = '{2'b11, INIT_AXI,  1'b0, 32'h0000_6000, 16'd2, 2'b10, 1'b0, 1'b1};
        rows[6] = '{2'b01, INIT_AXI,  1'b1, 32'h0000_7000, 16'd4, 2'b01, 1'b0, 1'b1};
        rows[7] = '{2'b01, INIT_AXI,  1'b0, 32'h0000_8000, 16'd3, 2'b01, 1'b0, 1'b1};
        repeat (2) @(posedge clk_phy_i);
        #1;
        rst_i = 1'b0;
        for (int k = 0; k < NumRows; k++) run_row(rows[k]);
        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
design/hyper_stream_pkg.sv
design/hyper_arb_pkg.sv
design/hyper_arbiter.sv
design/hyper_path_switch.sv
design/hyperbus_mux_top.sv
testbench/tb_hyperbus_mux.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing
TOP      ?= tb_hyperbus_mux
FILELIST ?= project.f
BUILD    ?= obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
